//--- design/mul_pkg.sv
package mul_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // Each operand
    localparam int OPERAND_W = 32;

    // Full product, no truncation
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // One partial product row per multiplier bit
    localparam int NUM_ROWS = OPERAND_W;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef logic [OPERAND_W-1:0] operand_t;

    typedef logic [PRODUCT_W-1:0] product_t;

    // Row i is the multiplicand gated by multiplier bit i, shifted left by i
    typedef product_t [NUM_ROWS-1:0] pp_rows_t;

    // Redundant form of a product
    // carry is already aligned to its weight, value is sum + carry mod 2**64
    typedef struct packed {
        product_t sum;
        product_t carry;
    } carry_save_t;

endpackage

//--- design/pp_gen.sv
module pp_gen
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    output pp_rows_t rows,
    output logic     rows_valid
);

    operand_t a_q;
    operand_t b_q;

    //////////////////////////////////////////////////////////////////////
    // Operand capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            a_q <= '0;
            b_q <= '0;
        end
        else if (in_valid)
        begin
            a_q <= a;
            b_q <= b;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rows_valid <= 1'b0;
        end
        else
        begin
            rows_valid <= in_valid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Partial product rows
    //////////////////////////////////////////////////////////////////////

    // AND with one multiplier bit, then move to that bit's weight
    for (genvar i = 0; i < NUM_ROWS; i++)
    begin : g_row
        assign rows[i] = product_t'(a_q & {OPERAND_W{b_q[i]}}) << i;
    end

endmodule

//--- design/wallace_reduce.sv
module wallace_reduce
    import mul_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  pp_rows_t    rows,
    input  logic        rows_valid,
    output carry_save_t cs,
    output logic        cs_valid
);

    // Rows present at the input of a given layer
    function automatic int rows_at(int layer);
        int n;
        n = NUM_ROWS;
        for (int l = 0; l < layer; l++)
        begin
            n = 2 * (n / 3) + n % 3;
        end
        return n;
    endfunction

    // Layers until only a sum and carry row remain
    function automatic int layers_needed();
        int n;
        int l;
        n = NUM_ROWS;
        l = 0;
        while (n > 2)
        begin
            n = 2 * (n / 3) + n % 3;
            l++;
        end
        return l;
    endfunction

    // 32 -> 22 -> 15 -> 10 -> 7 -> 5 -> 4 -> 3 -> 2
    localparam int NUM_LAYERS = layers_needed();

    product_t tree [NUM_LAYERS+1][NUM_ROWS];

    for (genvar i = 0; i < NUM_ROWS; i++)
    begin : g_in
        assign tree[0][i] = rows[i];
    end

    //////////////////////////////////////////////////////////////////////
    // Carry-save layers
    //////////////////////////////////////////////////////////////////////

    for (genvar l = 0; l < NUM_LAYERS; l++)
    begin : g_layer
        localparam int N_IN   = rows_at(l);
        localparam int N_OUT  = rows_at(l + 1);
        localparam int N_GRP  = N_IN / 3;
        localparam int N_LEFT = N_IN % 3;

        // 3:2 compressor per group, full adder on every bit
        for (genvar g = 0; g < N_GRP; g++)
        begin : g_csa
            product_t x;
            product_t y;
            product_t z;

            assign x = tree[l][3*g];
            assign y = tree[l][3*g+1];
            assign z = tree[l][3*g+2];

            assign tree[l+1][2*g]   = x ^ y ^ z;
            assign tree[l+1][2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
        end

        // One or two rows fall through to the next layer
        for (genvar r = 0; r < N_LEFT; r++)
        begin : g_pass
            assign tree[l+1][2*N_GRP+r] = tree[l][3*N_GRP+r];
        end

        // Slots past the live rows
        for (genvar u = N_OUT; u < NUM_ROWS; u++)
        begin : g_tie
            assign tree[l+1][u] = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cs <= '0;
        end
        else if (rows_valid)
        begin
            cs.sum   <= tree[NUM_LAYERS][0];
            cs.carry <= tree[NUM_LAYERS][1];
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cs_valid <= 1'b0;
        end
        else
        begin
            cs_valid <= rows_valid;
        end
    end

endmodule

//--- design/prefix_adder.sv
module prefix_adder
    import mul_pkg::*;
#(
    parameter int WIDTH = PRODUCT_W
)
(
    input  logic        clk,
    input  logic        arst_n,
    input  carry_save_t cs,
    input  logic        cs_valid,
    output product_t    product,
    output logic        out_valid
);

    // 00 kill, 10 propagate, 11 generate
    typedef logic [1:0] pgk_t;

    localparam int LEVELS = $clog2(WIDTH);

    logic [WIDTH-1:0] a_in;
    logic [WIDTH-1:0] b_in;
    logic [WIDTH-1:0] carry_in;
    logic [WIDTH-1:0] sum_w;

    pgk_t lvl [LEVELS+1][WIDTH];

    assign a_in = cs.sum[WIDTH-1:0];
    assign b_in = cs.carry[WIDTH-1:0];

    //////////////////////////////////////////////////////////////////////
    // Per-bit codes
    //////////////////////////////////////////////////////////////////////

    // Bit 0 sees a zero carry-in, so propagate there resolves to kill
    assign lvl[0][0] = {2{a_in[0] & b_in[0]}};

    for (genvar i = 1; i < WIDTH; i++)
    begin : g_code
        assign lvl[0][i] = {a_in[i] | b_in[i], a_in[i] & b_in[i]};
    end

    //////////////////////////////////////////////////////////////////////
    // Recursive doubling
    //////////////////////////////////////////////////////////////////////

    // Span doubles each level
    for (genvar k = 0; k < LEVELS; k++)
    begin : g_level
        localparam int SPAN = 1 << k;

        for (genvar i = 0; i < WIDTH; i++)
        begin : g_pos
            if (i < SPAN)
            begin : g_keep
                // Already resolved down to bit 0
                assign lvl[k+1][i] = lvl[k][i];
            end
            else
            begin : g_comb
                assign lvl[k+1][i][0] = lvl[k][i][0] | (lvl[k][i][1] & lvl[k][i-SPAN][0]);
                assign lvl[k+1][i][1] = lvl[k][i][0] | (lvl[k][i][1] & lvl[k][i-SPAN][1]);
            end
        end
    end

    // Resolved codes are kill or generate only
    assign carry_in[0] = 1'b0;

    for (genvar i = 1; i < WIDTH; i++)
    begin : g_carry
        assign carry_in[i] = lvl[LEVELS][i-1][1];
    end

    assign sum_w = a_in ^ b_in ^ carry_in;

    //////////////////////////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            product <= '0;
        end
        else if (cs_valid)
        begin
            product <= product_t'(sum_w);
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= cs_valid;
        end
    end

endmodule

//--- design/wallace_mul.sv
module wallace_mul
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    output logic     out_valid,
    output product_t product
);

    pp_rows_t    rows;
    logic        rows_valid;
    carry_save_t cs;
    logic        cs_valid;

    // Stage 1, operand capture and partial products
    pp_gen u_pp_gen (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .a          (a),
        .b          (b),
        .rows       (rows),
        .rows_valid (rows_valid)
    );

    // Stage 2, tree down to two rows
    wallace_reduce u_wallace_reduce (
        .clk        (clk),
        .arst_n     (arst_n),
        .rows       (rows),
        .rows_valid (rows_valid),
        .cs         (cs),
        .cs_valid   (cs_valid)
    );

    // Stage 3, final carry-propagate add
    prefix_adder #(
        .WIDTH (PRODUCT_W)
    ) u_prefix_adder (
        .clk       (clk),
        .arst_n    (arst_n),
        .cs        (cs),
        .cs_valid  (cs_valid),
        .product   (product),
        .out_valid (out_valid)
    );

endmodule

//--- tb/tb_wallace_mul.sv
module tb_wallace_mul
    import mul_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;
    localparam int RESET_CYCLES = 3;
    localparam int N_CORNER_X   = 8;
    localparam int N_CORNER     = 4 * N_CORNER_X + 4;
    localparam int N_CARRY      = 4 * OPERAND_W;
    localparam int N_STREAM     = 200;
    localparam int N_GAPPED     = 100;
    localparam int MAX_GAP      = 3;
    localparam int N_BURST      = 12;
    localparam int DRAIN_LIMIT  = 8;
    localparam int NUM_TESTS    = 5;
    localparam int MARGIN       = 50;

    // Worst-case length of every test plus its drain in cycles
    localparam int WATCHDOG_CYCLES = 2 * RESET_CYCLES + N_CORNER + N_CARRY + N_STREAM
        + N_GAPPED * (MAX_GAP + 1) + 2 * N_BURST + 4
        + NUM_TESTS * (DRAIN_LIMIT + 2) + MARGIN;

    logic     clk = 1'b0;
    logic     arst_n;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    product_t product;

    // Expected products in strobe order
    product_t   exp_q[$];
    logic [2:0] valid_hist = '0;

    integer seed         = 32'hd65b;
    int     errors       = 0;
    int     checks       = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;

    wallace_mul u_wallace_mul (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .product   (product)
    );

    initial
    begin
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic product_t expected_product(operand_t x, operand_t y);
        return product_t'(x) * product_t'(y);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Output checks on the falling edge where everything has settled
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin : monitor
        product_t expected;
        if (!arst_n)
        begin
            checks++;
            assert (out_valid === 1'b0 && product === '0)
            else
            begin
                $display("ERR t=%0t out_valid/product expected 0/%h got %b/%h",
                         $time, 64'h0, out_valid, product);
                errors++;
            end
            valid_hist = '0;
        end
        else
        begin
            // out_valid is in_valid three edges late
            checks++;
            assert (out_valid === valid_hist[2])
            else
            begin
                $display("ERR t=%0t out_valid expected %b got %b",
                         $time, valid_hist[2], out_valid);
                errors++;
            end
            if (out_valid === 1'b1)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("Product %h came out at t=%0t with no operation in flight",
                             product, $time);
                    errors++;
                end
                else
                begin
                    expected = exp_q.pop_front();
                    checks++;
                    assert (product === expected)
                    else
                    begin
                        $display("ERR t=%0t product expected %h got %h",
                                 $time, expected, product);
                        errors++;
                    end
                end
            end
            valid_hist = {valid_hist[1:0], in_valid};
            if (in_valid)
            begin
                exp_q.push_back(expected_product(a, b));
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic issue(input operand_t op_a, input operand_t op_b);
        in_valid = 1'b1;
        a        = op_a;
        b        = op_b;
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n)
        begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // Wait for every queued product up to a bound
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
        begin
            idle(1);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            $display("%0d products still missing %0d cycles after the last operation",
                     exp_q.size(), waited);
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int err_before, input int ops);
        if (errors == err_before)
        begin
            tests_passed++;
            $display("Test %s passed, %0d operations", name, ops);
        end
        else
        begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors - err_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic corner_products();
        int       err_before;
        operand_t x;
        err_before = errors;
        for (int i = 0; i < N_CORNER_X; i++)
        begin
            x = $random(seed);
            issue('0, x);
            issue(x, '0);
            issue(32'd1, x);
            issue(x, 32'd1);
        end
        issue('1, '1);
        issue('1, 32'd1);
        issue(32'd1, '1);
        issue('0, '0);
        drain();
        report_test("corner_products", err_before, N_CORNER);
    endtask

    // Long propagate runs through every prefix level
    task automatic carry_chains();
        int       err_before;
        operand_t p;
        err_before = errors;
        for (int i = 0; i < OPERAND_W; i++)
        begin
            p = operand_t'(1) << i;
            issue('1, p);
            issue(p, '1);
            issue(p, operand_t'(1) << (OPERAND_W - 1 - i));
            issue(p, p);
        end
        drain();
        report_test("carry_chains", err_before, N_CARRY);
    endtask

    task automatic back_to_back_stream();
        int err_before;
        err_before = errors;
        for (int i = 0; i < N_STREAM; i++)
        begin
            issue($random(seed), $random(seed));
        end
        drain();
        report_test("back_to_back_stream", err_before, N_STREAM);
    endtask

    task automatic gapped_strobes();
        int err_before;
        int gap;
        err_before = errors;
        for (int i = 0; i < N_GAPPED; i++)
        begin
            issue($random(seed), $random(seed));
            gap = $unsigned($random(seed)) % (MAX_GAP + 1);
            idle(gap);
        end
        drain();
        report_test("gapped_strobes", err_before, N_GAPPED);
    endtask

    // Reset lands with three operations still in the pipe
    task automatic reset_mid_stream();
        int err_before;
        err_before = errors;
        for (int i = 0; i < N_BURST; i++)
        begin
            issue($random(seed), $random(seed));
        end
        arst_n   = 1'b0;
        in_valid = 1'b0;
        exp_q.delete();
        idle(RESET_CYCLES);
        arst_n = 1'b1;
        idle(4);
        for (int i = 0; i < N_BURST; i++)
        begin
            issue($random(seed), $random(seed));
        end
        drain();
        report_test("reset_mid_stream", err_before, 2 * N_BURST);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        arst_n   = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        idle(2);

        corner_products();
        carry_chains();
        back_to_back_stream();
        gapped_strobes();
        reset_mid_stream();
        idle(4);

        $display("Tests passed %0d failed %0d, %0d checks with %0d errors",
                 tests_passed, tests_failed, checks, errors);
        if (tests_failed == 0 && errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- wallace_mul.f
design/mul_pkg.sv
design/pp_gen.sv
design/wallace_reduce.sv
design/prefix_adder.sv
design/wallace_mul.sv
tb/tb_wallace_mul.sv

//--- Bender.yml
package:
  name: wallace_mul

sources:
  # Package first, then the stages, then the top level
  - files:
      - design/mul_pkg.sv
      - design/pp_gen.sv
      - design/wallace_reduce.sv
      - design/prefix_adder.sv
      - design/wallace_mul.sv

  # Simulation only
  - target: test
    files:
      - tb/tb_wallace_mul.sv
